// File: build.f
rename_pkg.sv
rename_decode.sv
free_list.sv
rename_table.sv
rename_unit.sv
retire_queue.sv
rename_top.sv
tb_rename.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the rename testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rename -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_rename)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

// File: tb_rename.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rename;
    import rename_pkg::*;

    // opcode classes drawn by the lcg
    localparam int CLS_R      = 0;
    localparam int CLS_I      = 1;
    localparam int CLS_LOAD   = 2;
    localparam int CLS_STORE  = 3;
    localparam int CLS_BRANCH = 4;
    localparam int CLS_LUI    = 5;
    localparam int CLS_AUIPC  = 6;
    localparam int CLS_JAL    = 7;
    localparam int CLS_JALR   = 8;
    localparam int CLS_SYS    = 9; // csrrw
    localparam int NUM_CLS    = 10;

    typedef struct packed {
        logic        valid;
        logic        drop;
        logic        underflow;
        renamed_op_t op;
    } expect_t;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    instr_t      instr;
    logic        commit_valid;
    logic        rename_valid;
    logic        rename_drop;
    renamed_op_t rename_op;
    logic        commit_underflow;

    // reference model
    phys_reg_t   alias_map [NUM_ARCH_REGS];
    phys_reg_t   free_q [$];
    phys_reg_t   retire_q [$];  // displaced tags in age order
    phys_reg_t   rel_a;         // popped this cycle
    phys_reg_t   rel_b;         // lands in the free list at the coming edge
    logic        rel_a_valid;
    logic        rel_b_valid;
    logic [31:0] lcg_state;
    expect_t     exp_d;         // set together with the stimulus
    expect_t     exp_q;         // lines up with the registered outputs
    int          guard;
    int          cls;
    instr_t      word;
    logic [31:0] r;

    rename_top #(.FREE_DEPTH(32), .RETIRE_DEPTH(32)) UUT
    (
        .clk              (clk),
        .rst              (rst),
        .instr_valid      (instr_valid),
        .instr            (instr),
        .commit_valid     (commit_valid),
        .rename_valid     (rename_valid),
        .rename_drop      (rename_drop),
        .rename_op        (rename_op),
        .commit_underflow (commit_underflow)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #4 clk = ~clk; // 8 ns period
    end

    function automatic logic [31:0] rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // rv32i opcode per class with the other bits random
    function automatic instr_t build_instr(input int c, input logic [31:0] raw);
        instr_t w;
        w = raw;
        case (c)
            CLS_R:      w[6:0] = 7'b0110011;
            CLS_I:      w[6:0] = 7'b0010011;
            CLS_LOAD:   w[6:0] = 7'b0000011;
            CLS_STORE:  w[6:0] = 7'b0100011;
            CLS_BRANCH: w[6:0] = 7'b1100011;
            CLS_LUI:    w[6:0] = 7'b0110111;
            CLS_AUIPC:  w[6:0] = 7'b0010111;
            CLS_JAL:    w[6:0] = 7'b1101111;
            CLS_JALR:   w[6:0] = 7'b1100111;
            default:
            begin
                w[6:0]   = 7'b1110011;
                w[14:12] = 3'b001; // csrrw reads rs1 and writes rd
            end
        endcase
        return w;
    endfunction

    function automatic instr_t fields(input int c, input arch_reg_t rd,
                                      input arch_reg_t rs1, input arch_reg_t rs2);
        return build_instr(c, {7'h00, rs2, rs1, 3'b000, rd, 7'h00});
    endfunction

    // {writes_rd, uses_rs1, uses_rs2} from the isa formats
    function automatic logic [2:0] class_flags(input int c);
        case (c)
            CLS_R:                              return 3'b111;
            CLS_STORE, CLS_BRANCH:              return 3'b011;
            CLS_LUI, CLS_AUIPC, CLS_JAL:        return 3'b100;
            CLS_I, CLS_LOAD, CLS_JALR, CLS_SYS: return 3'b110;
            default:                            return 3'b000;
        endcase
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        stop_on_error($sformatf("FAILED %s: got %h expected %h", name, got, want));
    endtask

    // one cycle of stimulus plus the model's view of it
    task automatic drive_cycle(input logic v, input int c, input instr_t w, input logic commit);
        logic [2:0] fl;
        arch_reg_t  rd;
        arch_reg_t  rs1;
        arch_reg_t  rs2;
        expect_t    e;
        @(posedge clk);
        #1;
        instr_valid  = v;
        instr        = w;
        commit_valid = commit;
        fl  = class_flags(c);
        rd  = w[11:7];
        rs1 = w[19:15];
        rs2 = w[24:20];
        e   = '0;
        if (rel_b_valid)
            free_q.push_back(rel_b); // committed two cycles ago and usable now
        rel_b_valid = rel_a_valid;
        rel_b       = rel_a;
        rel_a_valid = 1'b0;
        if (commit)
        begin
            if (retire_q.size() == 0)
                e.underflow = 1'b1;
            else
            begin
                rel_a       = retire_q.pop_front();
                rel_a_valid = 1'b1;
            end
        end
        if (v)
        begin
            if (fl[1])
                e.op.prs1 = alias_map[rs1];
            if (fl[0])
                e.op.prs2 = alias_map[rs2];
            if (fl[2] && (rd != '0))
            begin
                if (free_q.size() == 0)
                    e.drop = 1'b1; // map stays as it was
                else
                begin
                    e.op.writes_rd = 1'b1;
                    e.op.prd       = free_q.pop_front();
                    e.op.old_prd   = alias_map[rd];
                    retire_q.push_back(alias_map[rd]);
                    alias_map[rd]  = e.op.prd;
                end
            end
            e.valid = !e.drop;
        end
        exp_d = e;
    endtask

    always @(posedge clk)
    begin
        exp_q <= exp_d;
    end

    // dut outputs against the model one cycle after each strobe
    a_valid: assert property (@(negedge clk) disable iff (rst)
        rename_valid == exp_q.valid)
        else report_mismatch("rename_valid", rename_valid, exp_q.valid);
    a_drop: assert property (@(negedge clk) disable iff (rst)
        rename_drop == exp_q.drop)
        else report_mismatch("rename_drop", rename_drop, exp_q.drop);
    a_underflow: assert property (@(negedge clk) disable iff (rst)
        commit_underflow == exp_q.underflow)
        else report_mismatch("commit_underflow", commit_underflow, exp_q.underflow);
    a_op: assert property (@(negedge clk) disable iff (rst)
        exp_q.valid |-> rename_op == exp_q.op)
        else report_mismatch("rename_op", rename_op, exp_q.op);

    initial
    begin
        rst          = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        commit_valid = 1'b0;
        exp_d        = '0;
        lcg_state    = 32'hee59_b45c;
        rel_a        = '0;
        rel_b        = '0;
        rel_a_valid  = 1'b0;
        rel_b_valid  = 1'b0;
        for (int i = 0; i < NUM_ARCH_REGS; i++)
            alias_map[i] = phys_reg_t'(i); // identity map out of reset
        for (int i = NUM_ARCH_REGS; i < NUM_PHYS_REGS; i++)
            free_q.push_back(phys_reg_t'(i));
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        drive_cycle(1'b0, CLS_R, '0, 1'b1);                          // commit with nothing to retire
        drive_cycle(1'b1, CLS_R, fields(CLS_R, 5'd5, 5'd1, 5'd2), 1'b0); // gets p32
        drive_cycle(1'b1, CLS_R, fields(CLS_R, 5'd6, 5'd5, 5'd5), 1'b0); // reads x5 just renamed
        drive_cycle(1'b1, CLS_STORE, fields(CLS_STORE, 5'd9, 5'd6, 5'd5), 1'b0);
        drive_cycle(1'b1, CLS_I, fields(CLS_I, 5'd0, 5'd6, 5'd0), 1'b0); // rd x0

        // use up the rest of the free tags
        guard = 0;
        while (free_q.size() > 0)
        begin
            word = build_instr(CLS_R, rand_word());
            if (word[11:7] == '0)
                word[11:7] = 5'd1;
            drive_cycle(1'b1, CLS_R, word, 1'b0);
            guard++;
            if (guard > 64)
                stop_on_error("free list never ran empty");
        end
        drive_cycle(1'b1, CLS_R, fields(CLS_R, 5'd7, 5'd3, 5'd4), 1'b0); // dropped
        drive_cycle(1'b1, CLS_STORE, fields(CLS_STORE, 5'd0, 5'd7, 5'd7), 1'b0);

        // released tag usable two cycles after its commit
        drive_cycle(1'b0, CLS_R, '0, 1'b1);
        drive_cycle(1'b1, CLS_R, fields(CLS_R, 5'd8, 5'd8, 5'd7), 1'b0); // still empty
        drive_cycle(1'b1, CLS_R, fields(CLS_R, 5'd8, 5'd8, 5'd7), 1'b0); // gets p5 back

        // drain the retire queue and add one commit too many
        guard = 0;
        while (retire_q.size() > 0)
        begin
            drive_cycle(1'b0, CLS_R, '0, 1'b1);
            guard++;
            if (guard > 64)
                stop_on_error("retire queue never drained");
        end
        drive_cycle(1'b0, CLS_R, '0, 1'b1);

        // random mix of renames and commits
        repeat (400)
        begin
            r    = rand_word();
            cls  = int'(r[31:16] % NUM_CLS);
            word = build_instr(cls, rand_word());
            drive_cycle(r[15:14] != 2'b00, cls, word, r[13:11] < 3'd3);
        end

        drive_cycle(1'b0, CLS_R, '0, 1'b0);
        drive_cycle(1'b0, CLS_R, '0, 1'b0);
        @(negedge clk);
        #1;
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: rename_top.sv
`timescale 1ns/10ps
`default_nettype none

module rename_top
#(
    parameter int FREE_DEPTH   = 32, // phys minus arch regs
    parameter int RETIRE_DEPTH = 32
)
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  rename_pkg::instr_t      instr,
    input  logic                    commit_valid,
    output logic                    rename_valid,
    output logic                    rename_drop,
    output rename_pkg::renamed_op_t rename_op,
    output logic                    commit_underflow
);
    import rename_pkg::*;

    decoded_op_t dec;
    logic        alloc_req;
    phys_reg_t   free_tag;
    logic        free_empty;
    logic        push_valid;
    phys_reg_t   push_tag;
    logic        release_valid;
    phys_reg_t   release_tag;

    rename_decode u_decode
    (
        .instr (instr),
        .dec   (dec)
    );

    rename_unit u_rename
    (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .dec          (dec),
        .alloc_req    (alloc_req),
        .free_tag     (free_tag),
        .free_empty   (free_empty),
        .push_valid   (push_valid),
        .push_tag     (push_tag),
        .rename_valid (rename_valid),
        .rename_drop  (rename_drop),
        .rename_op    (rename_op)
    );

    free_list #(.QUEUE_DEPTH(FREE_DEPTH)) u_free
    (
        .clk           (clk),
        .rst           (rst),
        .alloc_req     (alloc_req),
        .free_tag      (free_tag),
        .free_empty    (free_empty),
        .release_valid (release_valid), // back from retire, one cycle late
        .release_tag   (release_tag)
    );

    retire_queue #(.DEPTH(RETIRE_DEPTH)) u_retire
    (
        .clk              (clk),
        .rst              (rst),
        .push_valid       (push_valid),
        .push_tag         (push_tag),
        .commit_valid     (commit_valid),
        .release_valid    (release_valid),
        .release_tag      (release_tag),
        .commit_underflow (commit_underflow)
    );

endmodule

`default_nettype wire

// File: retire_queue.sv
`timescale 1ns/10ps
`default_nettype none

module retire_queue
#(
    parameter int DEPTH = 32
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push_valid,
    input  rename_pkg::phys_reg_t push_tag,
    input  logic                  commit_valid,
    output logic                  release_valid,    // one cycle after commit
    output rename_pkg::phys_reg_t release_tag,
    output logic                  commit_underflow
);
    import rename_pkg::*;

    localparam int AW = $clog2(DEPTH);

    typedef logic [AW:0] ptr_t; // wrap bit on top

    ptr_t      head;
    ptr_t      tail;
    phys_reg_t mem [DEPTH];
    logic      empty;
    logic      full;
    logic      do_push;
    logic      do_pop;

    assign empty   = (head == tail);
    assign full    = (head[AW-1:0] == tail[AW-1:0]) && (head[AW] != tail[AW]);
    assign do_push = push_valid && !full;
    assign do_pop  = commit_valid && !empty; // commit on empty is ignored

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            head             <= '0;
            tail             <= '0;
            release_valid    <= 1'b0;
            commit_underflow <= 1'b0;
        end
        else
        begin
            if (do_push)
                tail <= tail + 1'b1;
            if (do_pop)
                head <= head + 1'b1;
            release_valid    <= do_pop;
            commit_underflow <= commit_valid && empty;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[tail[AW-1:0]] <= push_tag;
        release_tag <= mem[head[AW-1:0]]; // oldest entry, used when release_valid
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        push_valid |-> !full);

endmodule

`default_nettype wire

// File: rename_unit.sv
`timescale 1ns/10ps
`default_nettype none

module rename_unit
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  rename_pkg::decoded_op_t dec,
    output logic                    alloc_req,
    input  rename_pkg::phys_reg_t   free_tag,
    input  logic                    free_empty,
    output logic                    push_valid,   // displaced tag to retire queue
    output rename_pkg::phys_reg_t   push_tag,
    output logic                    rename_valid,
    output logic                    rename_drop,
    output rename_pkg::renamed_op_t rename_op
);
    import rename_pkg::*;

    phys_reg_t   map_rs1;
    phys_reg_t   map_rs2;
    phys_reg_t   map_rd;   // mapping about to be displaced
    logic        needs_tag;
    logic        drop;
    renamed_op_t op_next;

    rename_table u_table
    (
        .clk     (clk),
        .rst     (rst),
        .rs1     (dec.rs1),
        .rs2     (dec.rs2),
        .rd      (dec.rd),
        .prs1    (map_rs1),
        .prs2    (map_rs2),
        .old_prd (map_rd),
        .wr_en   (alloc_req),   // map moves only on a real allocation
        .wr_arch (dec.rd),
        .wr_phys (free_tag)
    );

    assign needs_tag = instr_valid && dec.writes_rd;
    assign alloc_req = needs_tag && !free_empty;
    assign drop      = needs_tag && free_empty; // no stall, op is lost

    assign push_valid = alloc_req;
    assign push_tag   = map_rd;

    always_comb
    begin
        op_next.writes_rd = alloc_req;
        op_next.prd       = alloc_req ? free_tag : '0;
        op_next.old_prd   = alloc_req ? map_rd : '0;
        op_next.prs1      = dec.uses_rs1 ? map_rs1 : '0; // unused source reads as p0
        op_next.prs2      = dec.uses_rs2 ? map_rs2 : '0;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rename_valid <= 1'b0;
            rename_drop  <= 1'b0;
        end
        else
        begin
            rename_valid <= instr_valid && !drop;
            rename_drop  <= drop;
        end
    end

    always_ff @(posedge clk)
    begin
        rename_op <= op_next; // payload, qualified by rename_valid
    end

endmodule

`default_nettype wire

// File: rename_table.sv
`timescale 1ns/10ps
`default_nettype none

module rename_table
(
    input  logic                  clk,
    input  logic                  rst,
    input  rename_pkg::arch_reg_t rs1,
    input  rename_pkg::arch_reg_t rs2,
    input  rename_pkg::arch_reg_t rd,
    output rename_pkg::phys_reg_t prs1,
    output rename_pkg::phys_reg_t prs2,
    output rename_pkg::phys_reg_t old_prd,
    input  logic                  wr_en,
    input  rename_pkg::arch_reg_t wr_arch,
    input  rename_pkg::phys_reg_t wr_phys
);
    import rename_pkg::*;

    phys_reg_t map [NUM_ARCH_REGS]; // speculative arch -> phys

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            // identity map, xi -> pi
            for (int i = 0; i < NUM_ARCH_REGS; i++)
            begin
                map[i] <= phys_reg_t'(i);
            end
        end
        else if (wr_en && (wr_arch != '0))
        begin
            map[wr_arch] <= wr_phys; // seen by readers from next cycle
        end
    end

    // x0 reads as p0 whatever the entry holds
    assign prs1    = (rs1 == '0) ? '0 : map[rs1];
    assign prs2    = (rs2 == '0) ? '0 : map[rs2];
    assign old_prd = (rd  == '0) ? '0 : map[rd];

    // decode must have cleared writes_rd for x0
    a_no_write_x0: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> wr_arch != '0);

endmodule

`default_nettype wire

// File: free_list.sv
`timescale 1ns/10ps
`default_nettype none

module free_list
#(
    parameter int QUEUE_DEPTH = 32
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 alloc_req,     // pop head
    output rename_pkg::phys_reg_t free_tag,
    output logic                 free_empty,
    input  logic                 release_valid, // push at tail
    input  rename_pkg::phys_reg_t release_tag
);
    import rename_pkg::*;

    localparam int AW = $clog2(QUEUE_DEPTH);

    typedef logic [AW:0] ptr_t; // msb is the wrap bit

    ptr_t      head;
    ptr_t      tail;
    phys_reg_t mem [QUEUE_DEPTH];
    logic      empty;
    logic      full;
    logic      do_pop;

    // same index, wrap bits tell full from empty
    assign empty = (head == tail);
    assign full  = (head[AW-1:0] == tail[AW-1:0]) && (head[AW] != tail[AW]);

    assign do_pop     = alloc_req && !empty;
    assign free_tag   = mem[head[AW-1:0]]; // head entry visible with no latency
    assign free_empty = empty;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            head <= '0;
            tail <= {1'b1, {AW{1'b0}}}; // starts full
        end
        else
        begin
            if (do_pop)
                head <= head + 1'b1;
            if (release_valid)
                tail <= tail + 1'b1;   // pop and push can share a cycle
        end
    end

    // preload p32 upward, the tags not in the reset map
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < QUEUE_DEPTH; i++)
            begin
                mem[i] <= phys_reg_t'(NUM_ARCH_REGS + i);
            end
        end
        else if (release_valid)
            mem[tail[AW-1:0]] <= release_tag;
    end

    // tag count is conserved, so a release never meets a full list
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        release_valid |-> !full);
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        alloc_req |-> !empty);
    // p0 belongs to x0 forever
    a_no_free_p0: assert property (@(posedge clk) disable iff (rst)
        release_valid |-> release_tag != '0);

endmodule

`default_nettype wire

// File: rename_decode.sv
`timescale 1ns/10ps
`default_nettype none

module rename_decode
(
    input  rename_pkg::instr_t      instr,
    output rename_pkg::decoded_op_t dec
);
    import rename_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       has_rd; // format has an rd field that is written

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    always_comb
    begin
        // register fields sit at fixed positions in every format
        dec.rd       = instr[11:7];
        dec.rs1      = instr[19:15];
        dec.rs2      = instr[24:20];
        has_rd       = 1'b0;
        dec.uses_rs1 = 1'b0;
        dec.uses_rs2 = 1'b0;
        case (opcode)
            OP_REG:
            begin
                has_rd       = 1'b1;
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
            end
            OP_IMM, OP_LOAD, OP_JALR:
            begin
                has_rd       = 1'b1;
                dec.uses_rs1 = 1'b1;
            end
            OP_STORE, OP_BRANCH:
            begin
                dec.uses_rs1 = 1'b1; // base / compare operands
                dec.uses_rs2 = 1'b1;
            end
            OP_LUI, OP_AUIPC, OP_JAL:
                has_rd = 1'b1;      // no register sources
            OP_SYSTEM:
            begin
                has_rd       = (funct3 != 3'b000); // csr ops only, ecall/ebreak none
                dec.uses_rs1 = (funct3 != 3'b000) && !funct3[2]; // csrxxi uses uimm
            end
            default: ;              // fence and unknown, no regs
        endcase
        dec.writes_rd = has_rd && (dec.rd != '0); // x0 writes are discarded
    end

endmodule

`default_nettype wire

// File: rename_pkg.sv
`default_nettype none

package rename_pkg;

    localparam int unsigned NUM_ARCH_REGS = 32;
    localparam int unsigned NUM_PHYS_REGS = 64;

    typedef logic [$clog2(NUM_ARCH_REGS)-1:0] arch_reg_t; // x0..x31
    typedef logic [$clog2(NUM_PHYS_REGS)-1:0] phys_reg_t; // p0..p63
    typedef logic [31:0]                      instr_t;
    typedef logic [6:0]                       opcode_t;

    // rv32i major opcodes
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_SYSTEM = 7'b1110011;

    // 18 bits, decoder to rename stage
    typedef struct packed {
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
        logic      writes_rd; // never set for x0
        logic      uses_rs1;
        logic      uses_rs2;
    } decoded_op_t;

    // 25 bits, unused tags are zero
    typedef struct packed {
        phys_reg_t prd;
        phys_reg_t old_prd;   // displaced mapping, freed at commit
        phys_reg_t prs1;
        phys_reg_t prs2;
        logic      writes_rd;
    } renamed_op_t;

endpackage

`default_nettype wire
